//--- sim.f
design/yaw_pkg.sv
design/yaw_ifs.sv
design/yaw_sequencer.sv
design/yaw_input_sampler.sv
design/yaw_heading_tracker.sv
design/yaw_error_unit.sv
design/yaw_angle_accumulator.sv
test/yaw_angle_accumulator_assert.sv
test/tb_yaw_angle_accumulator.sv

//--- Bender.yml
package:
  name: yaw_angle_accumulator

sources:
  - files:
      - design/yaw_pkg.sv
      - design/yaw_ifs.sv
      - design/yaw_sequencer.sv
      - design/yaw_input_sampler.sv
      - design/yaw_heading_tracker.sv
      - design/yaw_error_unit.sv
      - design/yaw_angle_accumulator.sv
  - target: test
    files:
      - test/yaw_angle_accumulator_assert.sv
      - test/tb_yaw_angle_accumulator.sv

//--- test/tb_yaw_angle_accumulator.sv
/*
  Testbench for the yaw heading accumulator.
  Checks reset values and the ready gate, then runs directed and LFSR driven
  requests through the start/done handshake and compares target_angle,
  error_out and stick_active against a reference model of the heading rules.
*/
`timescale 1ns/1ps

module tb_yaw_angle_accumulator;
	import yaw_pkg::*;

	localparam int SCALE_BITS     = 2;
	localparam int IDLE_THRESHOLD = 10;
	localparam int NEUTRAL_WINDOW = 4;
	localparam int STICK_GAIN     = 2;
	localparam int CLK_PERIOD     = 100;
	localparam int HOLD           = 2;
	localparam int DONE_TIMEOUT   = 12;
	localparam int RANDOM_RUNS    = 300;
	// Angle scale, 16 counts per degree
	localparam int TURN           = 5760;
	localparam int QUARTER        = 1440;
	localparam int THREE_QUARTER  = 4320;

	logic   us_clk;
	logic   resetn;
	stick_t throttle;
	stick_t yaw_stick;
	angle_t yaw_angle_imu;
	logic   gain_sel;
	logic   bypass_n;
	logic   start;
	logic   imu_ready;
	angle_t target_angle;
	angle_t error_out;
	logic   stick_active;
	logic   busy;
	logic   done;

	logic [31:0] lfsr;
	int          imu_walk;
	int          run_idx;

	// Reference model state
	angle_t m_imu;
	angle_t m_track;
	angle_t m_err;
	int     m_neutral;

	yaw_angle_accumulator #(
		.SCALE_BITS     (SCALE_BITS),
		.IDLE_THRESHOLD (IDLE_THRESHOLD),
		.NEUTRAL_WINDOW (NEUTRAL_WINDOW),
		.STICK_GAIN     (STICK_GAIN)
	) i_dut (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.throttle      (throttle),
		.yaw_stick     (yaw_stick),
		.yaw_angle_imu (yaw_angle_imu),
		.gain_sel      (gain_sel),
		.bypass_n      (bypass_n),
		.start         (start),
		.imu_ready     (imu_ready),
		.target_angle  (target_angle),
		.error_out     (error_out),
		.stick_active  (stick_active),
		.busy          (busy),
		.done          (done)
	);

	always #(CLK_PERIOD / 2) us_clk = ~us_clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_angle(input angle_t actual, input angle_t expected, input string what);
		if (actual !== expected)
			fail_run($sformatf("error: %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			fail_run($sformatf("error: %0d ns: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	// Fibonacci LFSR with taps 32, 22, 2, 1
	function automatic logic next_random_bit();
		logic feedback;
		feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], feedback};
		return feedback;
	endfunction

	function automatic int random_bits(input int count);
		int value;
		int bit_idx;
		value = 0;
		for (bit_idx = 0; bit_idx < count; bit_idx++)
			value = (value << 1) | int'(next_random_bit());
		return value;
	endfunction

	task automatic set_inputs(input stick_t thr, input stick_t stk, input angle_t imu,
			input logic gain, input logic byp);
		throttle      = thr;
		yaw_stick     = stk;
		yaw_angle_imu = imu;
		gain_sel      = gain;
		bypass_n      = byp;
	endtask

	task automatic drive_random_inputs();
		// Idle throttle about one request in four
		if (random_bits(2) == 0)
			throttle = stick_t'(random_bits(8) % IDLE_THRESHOLD);
		else
			throttle = stick_t'(IDLE_THRESHOLD + random_bits(8) % (256 - IDLE_THRESHOLD));
		// Mostly small moves around mid stick, sometimes a full deflection
		if (random_bits(3) == 0)
			yaw_stick = stick_t'(random_bits(8));
		else
			yaw_stick = stick_t'(120 + random_bits(4));
		// IMU heading walks by up to 8 degrees per request
		imu_walk = (imu_walk + random_bits(8) + TURN - 128) % (TURN + 1);
		if (random_bits(4) == 0)
			yaw_angle_imu = random_bits(1) ? angle_t'(-1 - random_bits(10))
			                               : angle_t'(TURN + 1 + random_bits(10));
		else
			yaw_angle_imu = angle_t'(imu_walk);
		gain_sel = (random_bits(1) != 0);
		bypass_n = (random_bits(2) == 0);
	endtask

	// Predicts one request from the current inputs and advances the model state
	task automatic model_request(output angle_t exp_target, output angle_t exp_error,
			output logic exp_active);
		logic idle;
		int   norm;
		int   scaled_turn;
		int   track;
		int   tgt;
		int   raw;
		int   held;

		idle = (throttle < IDLE_THRESHOLD);
		if ((yaw_angle_imu >= 0) && (yaw_angle_imu <= TURN))
			m_imu = yaw_angle_imu;
		if (idle)
			m_neutral = yaw_stick;
		norm = (int'(yaw_stick) - m_neutral) * (gain_sel ? STICK_GAIN : 1);
		exp_active = !idle && ((norm >= NEUTRAL_WINDOW) || (norm <= -NEUTRAL_WINDOW));

		scaled_turn = TURN * (1 << SCALE_BITS);
		track = m_track;
		if (idle) begin
			track = m_imu * (1 << SCALE_BITS);
		end else if (exp_active) begin
			track = m_track + norm;
			if (track > scaled_turn)
				track = track - scaled_turn;
			else if (track < 0)
				track = track + scaled_turn;
		end
		// Saturated error blocks a command in the same direction
		if (((m_err >= QUARTER) && (norm > 0)) || ((m_err <= -QUARTER) && (norm < 0)))
			track = m_track;
		m_track = angle_t'(track);
		tgt = idle ? m_imu : (track / (1 << SCALE_BITS));

		if (idle)
			raw = 0;
		else if ((tgt > THREE_QUARTER) && (m_imu < QUARTER))
			raw = -(TURN - tgt + m_imu);
		else if ((m_imu > THREE_QUARTER) && (tgt < QUARTER))
			raw = TURN - m_imu + tgt;
		else
			raw = tgt - m_imu;
		if ((m_err >= QUARTER) && (raw <= -QUARTER))
			held = QUARTER;
		else if ((m_err <= -QUARTER) && (raw >= QUARTER))
			held = -QUARTER;
		else
			held = raw;
		m_err = angle_t'(held);

		if (bypass_n) begin
			exp_target = angle_t'(int'(yaw_stick));
			exp_error  = '0;
		end else begin
			exp_target = angle_t'(tgt);
			if (held > QUARTER)
				exp_error = angle_t'(QUARTER);
			else if (held < -QUARTER)
				exp_error = angle_t'(-QUARTER);
			else
				exp_error = angle_t'(held);
		end
	endtask

	task automatic check_start_before_ready();
		int cycle;
		start = 1'b1;
		for (cycle = 0; cycle < 20; cycle++) begin
			@(posedge us_clk);
			#HOLD;
			start = 1'b0;
			check_flag(done, 1'b0, "done before imu_ready");
			check_flag(busy, 1'b0, "busy before imu_ready");
		end
	endtask

	// One start/done handshake; extra_start adds a start while busy
	task automatic run_request(input logic extra_start);
		angle_t exp_target;
		angle_t exp_error;
		logic   exp_active;
		int     edges;

		model_request(exp_target, exp_error, exp_active);
		start = 1'b1;
		@(posedge us_clk);
		#HOLD;
		start = 1'b0;
		edges = 0;
		while (!done) begin
			if (edges >= DONE_TIMEOUT)
				fail_run("Timed out waiting for done after an accepted start");
			check_flag(busy, 1'b1, "busy while request runs");
			start = extra_start && (edges == 2);
			@(posedge us_clk);
			#HOLD;
			edges++;
		end
		if (edges != 5)
			fail_run($sformatf("error: %0d ns: done came %0d edges after start, expected 5",
				$time, edges));
		check_flag(busy, 1'b0, "busy with done");
		check_angle(target_angle, exp_target, "target_angle");
		check_angle(error_out, exp_error, "error_out");
		check_flag(stick_active, exp_active, "stick_active");

		// A start taken while busy would show up as a new busy period here
		@(posedge us_clk);
		#HOLD;
		check_flag(done, 1'b0, "done one cycle later");
		check_flag(busy, 1'b0, "busy after done");
	endtask

	initial begin
		us_clk    = 1'b0;
		resetn    = 1'b0;
		start     = 1'b0;
		imu_ready = 1'b0;
		set_inputs(8'd0, 8'd0, 16'sd0, 1'b0, 1'b0);
		lfsr      = 32'hfa6c1b04;
		imu_walk  = 2000;
		m_imu     = '0;
		m_track   = '0;
		m_err     = '0;
		m_neutral = 0;

		repeat (8) @(posedge us_clk);
		#HOLD;
		resetn = 1'b1;

		check_angle(target_angle, 16'sd0, "target_angle after reset");
		check_angle(error_out, 16'sd0, "error_out after reset");
		check_flag(stick_active, 1'b0, "stick_active after reset");
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(done, 1'b0, "done after reset");
		check_start_before_ready();

		imu_ready = 1'b1;
		@(posedge us_clk);
		#HOLD;

		// Idle throttle captures neutral, then the same stick is neutral
		set_inputs(8'd0, 8'd128, 16'sd1000, 1'b0, 1'b0);
		run_request(1'b0);
		set_inputs(8'd100, 8'd128, 16'sd1200, 1'b1, 1'b0);
		run_request(1'b1);

		// Track wraps through 0 and then back through 360
		set_inputs(8'd0, 8'd128, 16'sd10, 1'b0, 1'b0);
		run_request(1'b0);
		set_inputs(8'd100, 8'd0, 16'sd10, 1'b0, 1'b0);
		run_request(1'b0);
		set_inputs(8'd100, 8'd255, 16'sd10, 1'b0, 1'b0);
		run_request(1'b0);

		// Large error brings in the clamp, the command drop and the anti-wrap hold
		set_inputs(8'd100, 8'd128, 16'sd4000, 1'b0, 1'b0);
		run_request(1'b0);
		set_inputs(8'd100, 8'd0, 16'sd4000, 1'b1, 1'b0);
		run_request(1'b0);
		set_inputs(8'd100, 8'd128, 16'sd4321, 1'b0, 1'b0);
		run_request(1'b0);

		for (run_idx = 0; run_idx < RANDOM_RUNS; run_idx++) begin
			drive_random_inputs();
			run_request(run_idx % 5 == 0);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- test/yaw_angle_accumulator_assert.sv
/*
  Concurrent checks on the yaw accumulator top level.
  Bound to every instance of yaw_angle_accumulator; covers the start/done
  handshake timing and the range of the clamped error output.
*/
`timescale 1ns/1ps

module yaw_angle_accumulator_assert (
	input logic            us_clk,
	input logic            resetn,
	input logic            start,
	input logic            imu_ready,
	input logic            busy,
	input logic            done,
	input yaw_pkg::angle_t error_out
);
	import yaw_pkg::*;

	logic ready_seen;
	logic accepted;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			ready_seen <= 1'b0;
		else if (imu_ready)
			ready_seen <= 1'b1;
	end

	// Start only counts when the sequencer is idle after the IMU came up
	assign accepted = start && ready_seen && !busy;

	a_done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	a_busy_done_excl: assert property (@(posedge us_clk) disable iff (!resetn)
		!(busy && done))
		else $error("busy and done high together");

	a_error_range: assert property (@(posedge us_clk) disable iff (!resetn)
		(error_out >= -ANGLE_90) && (error_out <= ANGLE_90))
		else $error("error_out outside +/-90 degrees");

	// done rises on the fifth edge and is sampled high on the sixth
	a_done_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		accepted |=> !done [*5] ##1 done)
		else $error("done did not follow an accepted start after 5 edges");

endmodule

bind yaw_angle_accumulator yaw_angle_accumulator_assert i_assert (
	.us_clk    (us_clk),
	.resetn    (resetn),
	.start     (start),
	.imu_ready (imu_ready),
	.busy      (busy),
	.done      (done),
	.error_out (error_out)
);

//--- design/yaw_angle_accumulator.sv
/*
  Yaw heading accumulator, top level.
  Pulse start once imu_ready has been seen; five edges later target_angle,
  error_out and stick_active are updated and done pulses for one cycle.
  Starts while busy are ignored. Only instances and wiring live here.
*/
`timescale 1ns/1ps

module yaw_angle_accumulator #(
	parameter int SCALE_BITS     = 2,
	parameter int IDLE_THRESHOLD = 10,
	parameter int NEUTRAL_WINDOW = 4,
	parameter int STICK_GAIN     = 2
) (
	input  logic             us_clk,
	input  logic             resetn,
	input  yaw_pkg::stick_t  throttle,
	input  yaw_pkg::stick_t  yaw_stick,
	input  yaw_pkg::angle_t  yaw_angle_imu,
	input  logic             gain_sel,
	input  logic             bypass_n,
	input  logic             start,
	input  logic             imu_ready,
	output yaw_pkg::angle_t  target_angle,
	output yaw_pkg::angle_t  error_out,
	output logic             stick_active,
	output logic             busy,
	output logic             done
);
	import yaw_pkg::*;

	angle_t target;
	angle_t error_state;

	yaw_step_if   steps ();
	yaw_sample_if sample ();

	yaw_sequencer i_sequencer (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.start     (start),
		.imu_ready (imu_ready),
		.steps     (steps.seq),
		.busy      (busy),
		.done      (done)
	);

	yaw_input_sampler #(
		.IDLE_THRESHOLD (IDLE_THRESHOLD),
		.STICK_GAIN     (STICK_GAIN)
	) i_sampler (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.throttle      (throttle),
		.yaw_stick     (yaw_stick),
		.yaw_angle_imu (yaw_angle_imu),
		.gain_sel      (gain_sel),
		.steps         (steps.unit),
		.sample        (sample.src)
	);

	yaw_heading_tracker #(
		.SCALE_BITS     (SCALE_BITS),
		.NEUTRAL_WINDOW (NEUTRAL_WINDOW)
	) i_tracker (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.steps        (steps.unit),
		.sample       (sample.dst),
		.error_state  (error_state),
		.target       (target),
		.stick_active (stick_active)
	);

	yaw_error_unit i_error_unit (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.steps        (steps.unit),
		.sample       (sample.dst),
		.target       (target),
		.bypass_n     (bypass_n),
		.error_state  (error_state),
		.target_angle (target_angle),
		.error_out    (error_out)
	);

endmodule

//--- design/yaw_error_unit.sv
/*
  Heading error and output stage.
  Computes the target minus IMU error the short way around the circle,
  holds the error at +/-90 degrees instead of letting it flip sides, and
  registers the clamped outputs. With bypass_n high the raw stick is passed
  out as the target and the error output is zero.
*/
`timescale 1ns/1ps

module yaw_error_unit (
	input  logic             us_clk,
	input  logic             resetn,
	yaw_step_if.unit         steps,
	yaw_sample_if.dst        sample,
	input  yaw_pkg::angle_t  target,
	input  logic             bypass_n,
	output yaw_pkg::angle_t  error_state,
	output yaw_pkg::angle_t  target_angle,
	output yaw_pkg::angle_t  error_out
);
	import yaw_pkg::*;

	angle_t raw_error;
	angle_t held_error;
	angle_t clamped_error;

	always_comb begin
		if (sample.throttle_idle)
			raw_error = '0;
		else if ((target > ANGLE_270) && (sample.imu_angle < ANGLE_90))
			raw_error = -(ANGLE_360 - target + sample.imu_angle);
		else if ((sample.imu_angle > ANGLE_270) && (target < ANGLE_90))
			raw_error = ANGLE_360 - sample.imu_angle + target;
		else
			raw_error = target - sample.imu_angle;
	end

	// Anti-wrap: keep the side the error was saturated on
	always_comb begin
		if ((error_state >= ANGLE_90) && (raw_error <= -ANGLE_90))
			held_error = ANGLE_90;
		else if ((error_state <= -ANGLE_90) && (raw_error >= ANGLE_90))
			held_error = -ANGLE_90;
		else
			held_error = raw_error;
	end

	always_comb begin
		if (error_state > ANGLE_90)
			clamped_error = ANGLE_90;
		else if (error_state < -ANGLE_90)
			clamped_error = -ANGLE_90;
		else
			clamped_error = error_state;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			error_state  <= '0;
			target_angle <= '0;
			error_out    <= '0;
		end else begin
			if (steps.error_en)
				error_state <= held_error;
			if (steps.output_en) begin
				if (bypass_n) begin
					target_angle <= sample.stick_raw;
					error_out    <= '0;
				end else begin
					target_angle <= target;
					error_out    <= clamped_error;
				end
			end
		end
	end

endmodule

//--- design/yaw_heading_tracker.sv
/*
  Target heading tracker.
  Keeps the target heading with SCALE_BITS extra fraction bits so small stick
  deflections still accumulate. The heading follows the IMU while the
  throttle is idle and wraps at 360 degrees otherwise. A stick command that
  would push an already saturated error further is dropped.
*/
`timescale 1ns/1ps

module yaw_heading_tracker #(
	parameter int SCALE_BITS     = 2,
	parameter int NEUTRAL_WINDOW = 4
) (
	input  logic             us_clk,
	input  logic             resetn,
	yaw_step_if.unit         steps,
	yaw_sample_if.dst        sample,
	input  yaw_pkg::angle_t  error_state,
	output yaw_pkg::angle_t  target,
	output logic             stick_active
);
	import yaw_pkg::*;

	localparam angle_t ANGLE_360_SCALED = angle_t'(ANGLE_360 <<< SCALE_BITS);

	angle_t track_q;
	angle_t track_next;
	angle_t track_sum;
	angle_t stick_mag;
	logic   active_next;
	logic   drop_cmd;

	always_comb begin
		stick_mag   = sample.stick_norm[15] ? -sample.stick_norm : sample.stick_norm;
		active_next = !sample.throttle_idle && (stick_mag >= angle_t'(NEUTRAL_WINDOW));
		track_sum   = track_q + sample.stick_norm;

		// Error already at the limit in the direction of the stick
		drop_cmd = ((error_state >= ANGLE_90) && (sample.stick_norm > 16'sd0)) ||
		           ((error_state <= -ANGLE_90) && (sample.stick_norm < 16'sd0));

		if (sample.throttle_idle)
			track_next = sample.imu_angle <<< SCALE_BITS;
		else if (!active_next)
			track_next = track_q;
		else if (track_sum > ANGLE_360_SCALED)
			track_next = track_sum - ANGLE_360_SCALED;
		else if (track_sum < 16'sd0)
			track_next = track_sum + ANGLE_360_SCALED;
		else
			track_next = track_sum;

		if (drop_cmd)
			track_next = track_q;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_q      <= '0;
			stick_active <= 1'b0;
		end else if (steps.track_en) begin
			track_q      <= track_next;
			stick_active <= active_next;
		end
	end

	// Unscaled heading for the error stage
	assign target = sample.throttle_idle ? sample.imu_angle : (track_q >>> SCALE_BITS);

endmodule

//--- design/yaw_input_sampler.sv
/*
  Input capture and stick normalization.
  On the latch step the receiver values, the gain select and a valid IMU
  angle are captured. On the normalize step the neutral stick position is
  taken while the throttle is idle, and the stick deflection relative to it
  is produced, optionally multiplied by the stick gain.
*/
`timescale 1ns/1ps

module yaw_input_sampler #(
	parameter int IDLE_THRESHOLD = 10,
	parameter int STICK_GAIN     = 2
) (
	input  logic             us_clk,
	input  logic             resetn,
	input  yaw_pkg::stick_t  throttle,
	input  yaw_pkg::stick_t  yaw_stick,
	input  yaw_pkg::angle_t  yaw_angle_imu,
	input  logic             gain_sel,
	yaw_step_if.unit         steps,
	yaw_sample_if.src        sample
);
	import yaw_pkg::*;

	logic   idle_q;
	logic   gain_q;
	stick_t stick_q;
	angle_t imu_q;
	angle_t neutral_q;
	angle_t norm_q;

	logic   imu_valid;
	angle_t stick_ext;
	angle_t neutral_next;
	angle_t multiplier;

	// Reject IMU glitches outside 0 to 360 degrees
	assign imu_valid = (yaw_angle_imu >= 16'sd0) && (yaw_angle_imu <= IMU_ANGLE_MAX);

	assign stick_ext    = {8'h00, stick_q};
	assign neutral_next = idle_q ? stick_ext : neutral_q;
	assign multiplier   = gain_q ? angle_t'(STICK_GAIN) : 16'sd1;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			idle_q    <= 1'b0;
			gain_q    <= 1'b0;
			stick_q   <= '0;
			imu_q     <= '0;
			neutral_q <= '0;
			norm_q    <= '0;
		end else begin
			if (steps.latch_en) begin
				idle_q  <= (throttle < stick_t'(IDLE_THRESHOLD));
				gain_q  <= gain_sel;
				stick_q <= yaw_stick;
				if (imu_valid)
					imu_q <= yaw_angle_imu;
			end
			if (steps.norm_en) begin
				// Neutral only moves while the throttle is idle
				neutral_q <= neutral_next;
				norm_q    <= (stick_ext - neutral_next) * multiplier;
			end
		end
	end

	assign sample.throttle_idle = idle_q;
	assign sample.stick_norm    = norm_q;
	assign sample.imu_angle     = imu_q;
	assign sample.stick_raw     = stick_ext;

endmodule

//--- design/yaw_sequencer.sv
/*
  Control sequencer for the yaw accumulator.
  Waits for the IMU to report ready, then accepts one start at a time and
  walks through latch, normalize, track, error and output, one edge each.
  busy covers the five steps and done pulses for one cycle after output.
*/
`timescale 1ns/1ps

module yaw_sequencer (
	input  logic     us_clk,
	input  logic     resetn,
	input  logic     start,
	input  logic     imu_ready,
	yaw_step_if.seq  steps,
	output logic     busy,
	output logic     done
);
	import yaw_pkg::*;

	yaw_state_t state;
	yaw_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			st_wait_ready: if (imu_ready) state_next = st_idle;
			st_idle:       if (start) state_next = st_latch;
			st_latch:      state_next = st_normalize;
			st_normalize:  state_next = st_track;
			st_track:      state_next = st_error;
			st_error:      state_next = st_output;
			st_output:     state_next = st_idle;
			default:       state_next = st_wait_ready;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= st_wait_ready;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			// Result is registered on the output edge
			done  <= (state == st_output);
		end
	end

	// One strobe per step, decoded straight from the state
	assign steps.latch_en  = (state == st_latch);
	assign steps.norm_en   = (state == st_normalize);
	assign steps.track_en  = (state == st_track);
	assign steps.error_en  = (state == st_error);
	assign steps.output_en = (state == st_output);

	assign busy = (state != st_idle) && (state != st_wait_ready);

endmodule

//--- design/yaw_ifs.sv
/*
  Interfaces between the sequencer and the datapath units.
  yaw_step_if carries the one-hot step strobes, yaw_sample_if carries the
  latched and normalized inputs from the sampler to the later stages.
*/
`timescale 1ns/1ps

interface yaw_step_if;
	logic latch_en;
	logic norm_en;
	logic track_en;
	logic error_en;
	logic output_en;

	modport seq (output latch_en, norm_en, track_en, error_en, output_en);
	modport unit (input latch_en, norm_en, track_en, error_en, output_en);
endinterface

interface yaw_sample_if;
	import yaw_pkg::*;

	logic   throttle_idle;
	angle_t stick_norm;
	angle_t imu_angle;
	// Zero-extended raw stick, used by the bypass path
	angle_t stick_raw;

	modport src (output throttle_idle, stick_norm, imu_angle, stick_raw);
	modport dst (input throttle_idle, stick_norm, imu_angle, stick_raw);
endinterface

//--- design/yaw_pkg.sv
/*
  Shared types and constants for the yaw heading accumulator.
  Angles are 16-bit two's complement with 4 fractional bits, so 5760 counts
  make one full turn. Every design file imports this package where it needs
  the angle type, the angle constants or the sequencer state type.
*/
package yaw_pkg;

	// Angle or signed stick quantity, 4 fractional bits when it is an angle
	typedef logic signed [15:0] angle_t;

	// Raw receiver value
	typedef logic [7:0] stick_t;

	localparam angle_t ANGLE_360 = 16'sd5760;
	localparam angle_t ANGLE_270 = 16'sd4320;
	localparam angle_t ANGLE_90  = 16'sd1440;

	// Largest IMU reading that is accepted as valid
	localparam angle_t IMU_ANGLE_MAX = ANGLE_360;

	// Sequencer states, one per control step plus the two waiting states
	typedef enum logic [2:0] {
		st_wait_ready = 3'd0,
		st_idle       = 3'd1,
		st_latch      = 3'd2,
		st_normalize  = 3'd3,
		st_track      = 3'd4,
		st_error      = 3'd5,
		st_output     = 3'd6
	} yaw_state_t;

endpackage
